// File: verif/rvv_front_cases.txt
# mode(0 stall, 1 random, 2 ready) valid inst0 inst1 inst2 inst3, all hex
# then rs1 rs2 per lane 0..3 for the previous row's instructions
2 f 4123400 4456080 0011180 2022200 0 0 0 0 0 0 0 0
2 5 40920E5 0 4456080 0 11111111 0 22222222 0 33333333 0 44444444 0
1 a 0 4123400 0 59249E7 0000000C 0 0 0 55555555 0 0 0
1 f 4456080 50000E3 4456080 4123400 0 0 66666666 0 0 0 1F 0
2 0 0 0 0 0 88888888 0 00000020 000000C3 99999999 0 0 0
1 7 4456080 40920E5 4456080 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0A0A0A0A 0 00000005 0 0B0B0B0B 0 0 0
0 f 4456080 4123400 0011180 2022200 0 0 0 0 0 0 0 0
0 f 4456080 4123400 0011180 2022200 C0000001 0 C0000002 0 C0000003 0 C0000004 0
0 f 4456080 59249E7 0011180 2022200 C1000001 0 C1000002 0 C1000003 0 C1000004 0
0 f 4456080 4123400 0011180 2022200 C2000001 0 C2000002 0 C2000003 0 C2000004 0
0 f 4456080 4123400 0011180 2022200 C3000001 0 C3000002 0 C3000003 0 C3000004 0
0 0 0 0 0 0 C4000001 0 C4000002 0 C4000003 0 C4000004 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0
1 9 4456080 0 0 00330E1 0 0 0 0 0 0 0 0
1 6 0 40920E5 4456080 0 E0000001 0 0 0 0 0 E0000004 0
1 e 0 4123400 59249E7 4456080 0 0 00000007 0 F0000003 0 0 0
2 f 50000E3 4456080 40920E5 4123400 0 0 A1A1A1A1 0 0 0 B2B2B2B2 0
2 0 0 0 0 0 00000010 00000091 D1D1D1D1 0 00000007 0 0 0

// File: verilog.f
design/rvv_arch_pkg.sv
design/rvv_cmd_pkg.sv
design/rvv_cmd_aligner.sv
design/rvv_front_end.sv
design/rvv_cmd_queue.sv
design/rvv_core_front.sv
verif/tb_clock_gen.sv
verif/tb_rvv_core_front.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vector core front testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f verilog.f \
    --top-module tb_rvv_core_front -Mdir obj_dir; then
  echo "Build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_rvv_core_front > sim.log 2>&1; then
  cat sim.log
  echo "Simulation returned an error status"
  exit 1
fi

cat sim.log
if grep -q "All checks passed" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi

// File: verif/tb_rvv_core_front.sv
/*
 * Testbench for the vector core front
 * Plays case rows into the DUT, models vset*, acceptance and the
 * command FIFO, and compares every output each cycle
 */
`timescale 1ns/1ps

module tb_rvv_core_front;

  localparam int N              = 4;
  localparam int DEPTH          = 8;
  localparam int CLK_PERIOD     = 8;
  localparam int MAX_ROWS       = 64;
  localparam int CYCLES_PER_ROW = 20;

  logic clk;
  logic rstn;

  // DUT inputs and outputs
  rvv_arch_pkg::vstart_t          vstart_i;
  rvv_arch_pkg::rvv_xrm_e         vxrm_i;
  logic [N-1:0]                   inst_valid_i;
  rvv_cmd_pkg::rvv_inst_t [N-1:0] inst_data_i;
  logic [N-1:0]                   inst_ready_o;
  rvv_cmd_pkg::xreg_t [2*N-1:0]   reg_read_data_i;
  logic [N-1:0]                   reg_write_valid_o;
  rvv_cmd_pkg::xaddr_t [N-1:0]    reg_write_addr_o;
  rvv_cmd_pkg::xreg_t [N-1:0]     reg_write_data_o;
  logic                           deq_valid_o;
  rvv_cmd_pkg::rvv_cmd_t          deq_data_o;
  logic                           deq_ready_i;

  // Case rows as read from the file
  int unsigned            mode_mem [MAX_ROWS];
  logic [N-1:0]           valid_mem [MAX_ROWS];
  rvv_cmd_pkg::rvv_inst_t inst_mem [MAX_ROWS][N];
  rvv_cmd_pkg::xreg_t     reg_mem [MAX_ROWS][2*N];
  int                     num_rows;
  logic                   cases_loaded;

  // Reference model state
  rvv_arch_pkg::rvv_config_t model_cfg;
  logic [N-1:0]              pend_valid;
  rvv_cmd_pkg::rvv_inst_t    pend_inst [N];
  rvv_cmd_pkg::rvv_cmd_t     model_q [$];
  logic                      queue_filled;
  logic [15:0]               lfsr_state;

  tb_clock_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (2)
  ) i_tb_clock_gen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  rvv_core_front #(
    .N     (N),
    .DEPTH (DEPTH)
  ) i_rvv_core_front (
    .clk               (clk),
    .rstn              (rstn),
    .vstart_i          (vstart_i),
    .vxrm_i            (vxrm_i),
    .inst_valid_i      (inst_valid_i),
    .inst_data_i       (inst_data_i),
    .inst_ready_o      (inst_ready_o),
    .reg_read_data_i   (reg_read_data_i),
    .reg_write_valid_o (reg_write_valid_o),
    .reg_write_addr_o  (reg_write_addr_o),
    .reg_write_data_o  (reg_write_data_o),
    .deq_valid_o       (deq_valid_o),
    .deq_data_o        (deq_data_o),
    .deq_ready_i       (deq_ready_i)
  );

  task automatic stop_with_failure();
    $display("Checks failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_cmd(string name, rvv_cmd_pkg::rvv_cmd_t got,
                           rvv_cmd_pkg::rvv_cmd_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_xreg(string name, rvv_cmd_pkg::xreg_t got, rvv_cmd_pkg::xreg_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_xaddr(string name, rvv_cmd_pkg::xaddr_t got,
                             rvv_cmd_pkg::xaddr_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_ready(string name, logic [N-1:0] got, logic [N-1:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // vset* is op_rvv with funct3 all ones
  function automatic logic is_vset(rvv_cmd_pkg::rvv_inst_t inst);
    return (inst.opcode == rvv_cmd_pkg::op_rvv) && (inst.bits[7:5] == 3'b111);
  endfunction

  // New configuration after one vset* lane
  function automatic rvv_arch_pkg::rvv_config_t apply_vset(
    rvv_arch_pkg::rvv_config_t cfg, logic [24:0] b,
    rvv_cmd_pkg::xreg_t rs1, rvv_cmd_pkg::xreg_t rs2);
    rvv_arch_pkg::rvv_config_t next;
    next = cfg;
    // vsetivli: uimm in 12:8
    if (b[24:23] == 2'b11) begin
      next.vl = {27'b0, b[12:8]};
    end else begin
      next.vl = rs1;
    end
    // vsetvl: vtype from rs2
    if (b[24:23] == 2'b10) begin
      next.lmul = rvv_arch_pkg::rvv_lmul_e'(rs2[2:0]);
      next.sew  = rvv_arch_pkg::rvv_sew_e'(rs2[5:3]);
      next.ta   = rs2[6];
      next.ma   = rs2[7];
    end else begin
      next.lmul = rvv_arch_pkg::rvv_lmul_e'(b[15:13]);
      next.sew  = rvv_arch_pkg::rvv_sew_e'(b[18:16]);
      next.ta   = b[19];
      next.ma   = b[20];
    end
    return next;
  endfunction

  task automatic load_cases();
    int          fd;
    int          code;
    int          n_read;
    string       line;
    logic [31:0] f [14];
    fd = $fopen("verif/rvv_front_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file verif/rvv_front_cases.txt");
      stop_with_failure();
    end
    num_rows = 0;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      // Skip comments and blank lines
      if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
        n_read = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                         f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
        if (n_read != 14) begin
          $display("Malformed case row: %s", line);
          stop_with_failure();
        end
        if (num_rows >= MAX_ROWS) begin
          $display("Too many case rows in the file");
          stop_with_failure();
        end
        mode_mem[num_rows]  = f[0];
        valid_mem[num_rows] = f[1][N-1:0];
        for (int i = 0; i < N; i++) begin
          inst_mem[num_rows][i] = rvv_cmd_pkg::rvv_inst_t'(f[2+i][26:0]);
        end
        for (int k = 0; k < 2*N; k++) begin
          reg_mem[num_rows][k] = f[2+N+k];
        end
        num_rows++;
      end
    end
    $fclose(fd);
    cases_loaded = 1'b1;
  endtask

  // Mode 0 stalls the queue, 1 is random, 2 always drains
  task automatic drive_row(int r);
    inst_valid_i <= valid_mem[r];
    for (int i = 0; i < N; i++) begin
      inst_data_i[i] <= inst_mem[r][i];
    end
    for (int k = 0; k < 2*N; k++) begin
      reg_read_data_i[k] <= reg_mem[r][k];
    end
    case (mode_mem[r])
      0: deq_ready_i <= 1'b0;
      1: begin
        lfsr_state = lfsr_next(lfsr_state);
        deq_ready_i <= lfsr_state[0];
      end
      default: deq_ready_i <= 1'b1;
    endcase
  endtask

  // Compare one cycle, then advance the model across the next edge
  task automatic check_cycle();
    rvv_arch_pkg::rvv_config_t cur;
    rvv_cmd_pkg::rvv_cmd_t     new_cmds [$];
    rvv_cmd_pkg::rvv_cmd_t     c;
    rvv_cmd_pkg::xreg_t        rs1;
    rvv_cmd_pkg::xreg_t        rs2;
    logic [N-1:0]              exp_wvalid;
    logic [N-1:0]              exp_ready;
    int                        cap;
    int                        below;

    cur        = model_cfg;
    cur.vstart = vstart_i;
    cur.xrm    = vxrm_i;
    exp_wvalid = '0;
    // Lanes accepted last cycle, in program order
    for (int i = 0; i < N; i++) begin
      rs1 = reg_read_data_i[2*i];
      rs2 = reg_read_data_i[2*i+1];
      if (pend_valid[i] && is_vset(pend_inst[i])) begin
        cur = apply_vset(cur, pend_inst[i].bits, rs1, rs2);
        exp_wvalid[i] = 1'b1;
        check_xaddr($sformatf("reg_write_addr_o[%0d]", i), reg_write_addr_o[i],
                    pend_inst[i].bits[4:0]);
        check_xreg($sformatf("reg_write_data_o[%0d]", i), reg_write_data_o[i], cur.vl);
      end else if (pend_valid[i]) begin
        c.opcode     = pend_inst[i].opcode;
        c.bits       = pend_inst[i].bits;
        c.arch_state = cur;
        c.rs1        = pend_inst[i].bits[7] ? rs1 : 32'h0;
        new_cmds.push_back(c);
      end
    end
    check_ready("reg_write_valid_o", reg_write_valid_o, exp_wvalid);

    // Free slots after this cycle's commands land
    cap   = DEPTH - model_q.size() - new_cmds.size();
    below = 0;
    for (int i = 0; i < N; i++) begin
      exp_ready[i] = inst_valid_i[i] && (below < cap);
      if (inst_valid_i[i]) begin
        below++;
      end
    end
    check_ready("inst_ready_o", inst_ready_o, exp_ready);

    check_flag("deq_valid_o", deq_valid_o, model_q.size() != 0);
    if (model_q.size() != 0) begin
      check_cmd("deq_data_o", deq_data_o, model_q[0]);
      if (deq_ready_i) begin
        void'(model_q.pop_front());
      end
    end
    foreach (new_cmds[k]) begin
      model_q.push_back(new_cmds[k]);
    end
    // A full queue means inst_ready_o was checked at zero capacity
    if (model_q.size() == DEPTH) begin
      queue_filled = 1'b1;
    end

    model_cfg  = cur;
    pend_valid = exp_ready;
    for (int i = 0; i < N; i++) begin
      pend_inst[i] = inst_data_i[i];
    end
  endtask

  // Budget grows with the number of case rows
  initial begin
    wait (cases_loaded === 1'b1);
    #((num_rows * CYCLES_PER_ROW + DEPTH) * CLK_PERIOD);
    $display("Timeout: the run did not finish within its cycle budget");
    stop_with_failure();
  end

  initial begin
    cases_loaded    = 1'b0;
    queue_filled    = 1'b0;
    inst_valid_i    = '0;
    inst_data_i     = '0;
    reg_read_data_i = '0;
    deq_ready_i     = 1'b0;
    vstart_i        = 7'd3;
    vxrm_i          = rvv_arch_pkg::xrm_rdn;
    lfsr_state      = 16'd64;
    pend_valid      = '0;
    // Reset configuration: vl 16, sew8, lmul1, ta and ma clear
    model_cfg = '{vl: 32'd16, vstart: '0, xrm: rvv_arch_pkg::xrm_rnu,
                  sew: rvv_arch_pkg::sew8, lmul: rvv_arch_pkg::lmul1,
                  ta: 1'b0, ma: 1'b0};
    load_cases();

    wait (rstn === 1'b1);
    for (int r = 0; r < num_rows; r++) begin
      @(posedge clk);
      drive_row(r);
      @(negedge clk);
      check_cycle();
    end

    // Empty the queue with the dequeue side always ready
    while (model_q.size() != 0 || pend_valid != '0) begin
      @(posedge clk);
      inst_valid_i    <= '0;
      reg_read_data_i <= '0;
      deq_ready_i     <= 1'b1;
      @(negedge clk);
      check_cycle();
    end
    // Last dequeue takes effect at the next edge
    @(negedge clk);
    check_flag("deq_valid_o", deq_valid_o, 1'b0);
    if (!queue_filled) begin
      $display("Back-pressure rows never filled the command queue");
      stop_with_failure();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

// File: verif/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * Free-running clock, active-low reset held for a few cycles
 */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rstn_o
);

  // Half period toggle
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release reset on a rising edge after the hold time
  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rstn_o <= 1'b1;
  end

endmodule

// File: design/rvv_core_front.sv
/*
 * Vector core front
 * Front end feeding the command queue
 */
`timescale 1ns/1ps

module rvv_core_front #(
  parameter int N     = 4,
  parameter int DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  rvv_arch_pkg::vstart_t          vstart_i,
  input  rvv_arch_pkg::rvv_xrm_e         vxrm_i,
  input  logic [N-1:0]                   inst_valid_i,
  input  rvv_cmd_pkg::rvv_inst_t [N-1:0] inst_data_i,
  output logic [N-1:0]                   inst_ready_o,
  input  rvv_cmd_pkg::xreg_t [2*N-1:0]   reg_read_data_i,
  output logic [N-1:0]                   reg_write_valid_o,
  output rvv_cmd_pkg::xaddr_t [N-1:0]    reg_write_addr_o,
  output rvv_cmd_pkg::xreg_t [N-1:0]     reg_write_data_o,
  output logic                           deq_valid_o,
  output rvv_cmd_pkg::rvv_cmd_t          deq_data_o,
  input  logic                           deq_ready_i
);
  // Capacity spans 0..DEPTH
  localparam int CAP_BITS = $clog2(DEPTH + 1);

  logic [N-1:0]                  cmd_valid;
  rvv_cmd_pkg::rvv_cmd_t [N-1:0] cmd_data;
  logic [CAP_BITS-1:0]           capacity;

  rvv_front_end #(
    .N        (N),
    .CAP_BITS (CAP_BITS)
  ) i_rvv_front_end (
    .clk               (clk),
    .rstn              (rstn),
    .vstart_i          (vstart_i),
    .vxrm_i            (vxrm_i),
    .inst_valid_i      (inst_valid_i),
    .inst_data_i       (inst_data_i),
    .inst_ready_o      (inst_ready_o),
    .reg_read_data_i   (reg_read_data_i),
    .reg_write_valid_o (reg_write_valid_o),
    .reg_write_addr_o  (reg_write_addr_o),
    .reg_write_data_o  (reg_write_data_o),
    .cmd_valid_o       (cmd_valid),
    .cmd_data_o        (cmd_data),
    .capacity_i        (capacity)
  );

  rvv_cmd_queue #(
    .N        (N),
    .DEPTH    (DEPTH),
    .CAP_BITS (CAP_BITS)
  ) i_rvv_cmd_queue (
    .clk         (clk),
    .rstn        (rstn),
    .enq_valid_i (cmd_valid),
    .enq_data_i  (cmd_data),
    .capacity_o  (capacity),
    .deq_valid_o (deq_valid_o),
    .deq_data_o  (deq_data_o),
    .deq_ready_i (deq_ready_i)
  );

endmodule

// File: design/rvv_cmd_queue.sv
/*
 * Vector command queue
 * Circular buffer taking up to N aligned commands per cycle and
 * releasing one, with a free-slot count for back-pressure
 */
`timescale 1ns/1ps

module rvv_cmd_queue #(
  parameter int N        = 4,
  parameter int DEPTH    = 8,
  parameter int CAP_BITS = 4
) (
  input  logic                          clk,
  input  logic                          rstn,

  // Aligned enqueue lanes
  input  logic [N-1:0]                  enq_valid_i,
  input  rvv_cmd_pkg::rvv_cmd_t [N-1:0] enq_data_i,
  output logic [CAP_BITS-1:0]           capacity_o,

  // Single dequeue port
  output logic                          deq_valid_o,
  output rvv_cmd_pkg::rvv_cmd_t         deq_data_o,
  input  logic                          deq_ready_i
);
  localparam int PTR_BITS   = $clog2(DEPTH);
  localparam int COUNT_BITS = $clog2(N + 1);
  typedef logic [PTR_BITS-1:0] ptr_t;

  rvv_cmd_pkg::rvv_cmd_t mem [DEPTH];

  ptr_t                  rd_ptr_q;
  ptr_t                  wr_ptr_q;
  logic [CAP_BITS-1:0]   count_q;
  logic [COUNT_BITS-1:0] enq_count;
  logic                  deq_fire;

  // Pointer advance with wrap for any depth
  function automatic ptr_t ptr_add(ptr_t base, int unsigned offset);
    return ptr_t'((32'(base) + offset) % DEPTH);
  endfunction

  // Commands presented this cycle
  always_comb begin
    enq_count = '0;
    for (int i = 0; i < N; i++) begin
      enq_count = enq_count + COUNT_BITS'(enq_valid_i[i]);
    end
  end

  // Lanes are aligned, so lane i lands i slots past the tail
  always_ff @(posedge clk) begin
    for (int i = 0; i < N; i++) begin
      if (enq_valid_i[i]) begin
        mem[ptr_add(wr_ptr_q, i)] <= enq_data_i[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= ptr_add(wr_ptr_q, 32'(enq_count));
      if (deq_fire) begin
        rd_ptr_q <= ptr_add(rd_ptr_q, 1);
      end
      count_q <= count_q + CAP_BITS'(enq_count) - CAP_BITS'(deq_fire);
    end
  end

  assign deq_valid_o = (count_q != '0);
  assign deq_fire    = deq_valid_o && deq_ready_i;
  assign deq_data_o  = mem[rd_ptr_q];

  // Free slots left once the in-flight commands are written
  assign capacity_o = CAP_BITS'(DEPTH) - count_q - CAP_BITS'(enq_count);

endmodule

// File: design/rvv_front_end.sv
/*
 * Vector front end
 * Accepts dispatched lanes against queue capacity, applies vset* to the
 * configuration state, writes vl back and emits aligned commands
 */
`timescale 1ns/1ps

module rvv_front_end #(
  parameter int N        = 4,
  parameter int CAP_BITS = 4
) (
  input  logic                           clk,
  input  logic                           rstn,

  // Current CSR values, merged into every command
  input  rvv_arch_pkg::vstart_t          vstart_i,
  input  rvv_arch_pkg::rvv_xrm_e         vxrm_i,

  // Dispatched instructions, possibly unaligned
  input  logic [N-1:0]                   inst_valid_i,
  input  rvv_cmd_pkg::rvv_inst_t [N-1:0] inst_data_i,
  output logic [N-1:0]                   inst_ready_o,

  // Scalar operands one cycle after dispatch, rs1 then rs2 per lane
  input  rvv_cmd_pkg::xreg_t [2*N-1:0]   reg_read_data_i,

  // vl writeback for vset*
  output logic [N-1:0]                   reg_write_valid_o,
  output rvv_cmd_pkg::xaddr_t [N-1:0]    reg_write_addr_o,
  output rvv_cmd_pkg::xreg_t [N-1:0]     reg_write_data_o,

  // Aligned commands to the queue
  output logic [N-1:0]                   cmd_valid_o,
  output rvv_cmd_pkg::rvv_cmd_t [N-1:0]  cmd_data_o,
  input  logic [CAP_BITS-1:0]            capacity_i
);
  localparam int COUNT_BITS = $clog2(N + 1);
  typedef logic [COUNT_BITS-1:0] count_t;

  // Valid lanes below each lane
  count_t valid_psum [N];

  // Accepted instructions, waiting one cycle for operands
  logic [N-1:0]           valid_inst_q;
  rvv_cmd_pkg::rvv_inst_t inst_q [N];

  // Stored state and the state seen before each lane
  rvv_arch_pkg::rvv_config_t config_q;
  rvv_arch_pkg::rvv_config_t lane_cfg [N+1];
  logic [N-1:0]              is_cfg;

  // Commands before alignment
  logic [N-1:0]                  cmd_valid_raw;
  rvv_cmd_pkg::rvv_cmd_t [N-1:0] cmd_data_raw;

  always_comb begin
    valid_psum[0] = '0;
    for (int i = 1; i < N; i++) begin
      valid_psum[i] = valid_psum[i-1] + count_t'(inst_valid_i[i-1]);
    end
  end

  // Lane i fits when fewer than capacity valid lanes sit below it
  always_comb begin
    for (int i = 0; i < N; i++) begin
      inst_ready_o[i] = inst_valid_i[i] && (int'(valid_psum[i]) < int'(capacity_i));
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid_inst_q <= '0;
      config_q     <= rvv_arch_pkg::config_reset;
    end else begin
      valid_inst_q <= inst_ready_o;
      config_q     <= lane_cfg[N];
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < N; i++) begin
      inst_q[i] <= inst_data_i[i];
    end
  end

  // Walk lanes in program order, each vset* feeding the lanes above it
  always_comb begin
    rvv_cmd_pkg::inst_bits_t bits;
    rvv_cmd_pkg::xreg_t      rs1;
    rvv_cmd_pkg::xreg_t      rs2;

    lane_cfg[0]        = config_q;
    lane_cfg[0].vstart = vstart_i;
    lane_cfg[0].xrm    = vxrm_i;
    for (int i = 0; i < N; i++) begin
      bits = inst_q[i].bits;
      rs1  = reg_read_data_i[2*i];
      rs2  = reg_read_data_i[2*i+1];
      lane_cfg[i+1] = lane_cfg[i];

      is_cfg[i] = valid_inst_q[i] &&
                  (inst_q[i].opcode == rvv_cmd_pkg::op_rvv) &&
                  (bits[7:5] == rvv_cmd_pkg::funct3_cfg);

      if (is_cfg[i]) begin
        // vsetivli takes vl from uimm, the others from rs1
        if (bits[24:23] == rvv_cmd_pkg::sel_vsetivli) begin
          lane_cfg[i+1].vl = rvv_arch_pkg::vl_t'(bits[12:8]);
        end else begin
          lane_cfg[i+1].vl = rs1;
        end
        // vsetvl takes vtype from rs2, the others from zimm
        if (bits[24:23] == rvv_cmd_pkg::sel_vsetvl) begin
          lane_cfg[i+1].lmul = rvv_arch_pkg::rvv_lmul_e'(rs2[2:0]);
          lane_cfg[i+1].sew  = rvv_arch_pkg::rvv_sew_e'(rs2[5:3]);
          lane_cfg[i+1].ta   = rs2[6];
          lane_cfg[i+1].ma   = rs2[7];
        end else begin
          lane_cfg[i+1].lmul = rvv_arch_pkg::rvv_lmul_e'(bits[15:13]);
          lane_cfg[i+1].sew  = rvv_arch_pkg::rvv_sew_e'(bits[18:16]);
          lane_cfg[i+1].ta   = bits[19];
          lane_cfg[i+1].ma   = bits[20];
        end
      end

      // Non-config lanes carry the state in force before them
      cmd_valid_raw[i]           = valid_inst_q[i] && !is_cfg[i];
      cmd_data_raw[i].opcode     = inst_q[i].opcode;
      cmd_data_raw[i].bits       = bits;
      cmd_data_raw[i].arch_state = lane_cfg[i];
      cmd_data_raw[i].rs1        = bits[rvv_cmd_pkg::rs1_flag_bit] ? rs1 : '0;

      // New vl goes to rd
      reg_write_valid_o[i] = is_cfg[i];
      reg_write_addr_o[i]  = bits[4:0];
      reg_write_data_o[i]  = rvv_cmd_pkg::xreg_t'(lane_cfg[i+1].vl);
    end
  end

  rvv_cmd_aligner #(
    .N (N)
  ) i_rvv_cmd_aligner (
    .valid_i (cmd_valid_raw),
    .data_i  (cmd_data_raw),
    .valid_o (cmd_valid_o),
    .data_o  (cmd_data_o)
  );

endmodule

// File: design/rvv_cmd_aligner.sv
/*
 * Command lane aligner
 * Packs the valid lanes into the lowest lanes, keeping lane order
 */
`timescale 1ns/1ps

module rvv_cmd_aligner #(
  parameter int N = 4
) (
  input  logic [N-1:0]                  valid_i,
  input  rvv_cmd_pkg::rvv_cmd_t [N-1:0] data_i,
  output logic [N-1:0]                  valid_o,
  output rvv_cmd_pkg::rvv_cmd_t [N-1:0] data_o
);
  localparam int COUNT_BITS = $clog2(N + 1);
  typedef logic [COUNT_BITS-1:0] count_t;

  // Destination lane of each input lane, and number of valid lanes
  count_t lane_pos [N];
  count_t total;

  // Prefix count of valid lanes
  always_comb begin
    total = '0;
    for (int i = 0; i < N; i++) begin
      lane_pos[i] = total;
      total = total + count_t'(valid_i[i]);
    end
  end

  // Each output lane picks the single input whose position matches
  always_comb begin
    for (int j = 0; j < N; j++) begin
      valid_o[j] = int'(total) > j;
      data_o[j]  = '0;
      for (int i = 0; i < N; i++) begin
        if (valid_i[i] && (int'(lane_pos[i]) == j)) begin
          data_o[j] = data_i[i];
        end
      end
    end
  end

endmodule

// File: design/rvv_cmd_pkg.sv
/*
 * Vector instruction and command formats
 * Dispatched instruction, queued command and the field codes of the
 * vset* configuration instructions
 */
package rvv_cmd_pkg;

  // Scalar register file word and address
  typedef logic [31:0] xreg_t;
  typedef logic [4:0]  xaddr_t;

  // Instruction word above the 7-bit major opcode
  typedef logic [24:0] inst_bits_t;

  // Major opcode class
  typedef enum logic [1:0] {
    op_load  = 2'b00,
    op_store = 2'b01,
    op_rvv   = 2'b10
  } rvv_opcode_e;

  typedef struct packed {
    rvv_opcode_e opcode;
    inst_bits_t  bits;
  } rvv_inst_t;

  // Instruction plus the configuration it executes under
  typedef struct packed {
    rvv_opcode_e                opcode;
    inst_bits_t                 bits;
    rvv_arch_pkg::rvv_config_t  arch_state;
    xreg_t                      rs1;
  } rvv_cmd_t;

  // funct3 in bits 7:5, all ones for vset*
  localparam logic [2:0] funct3_cfg = 3'b111;

  // Bits 24:23 select the vset* flavour when bit 24 is set
  localparam logic [1:0] sel_vsetivli = 2'b11;
  localparam logic [1:0] sel_vsetvl   = 2'b10;

  // funct3 msb, set for the .vx/.vf forms that read rs1
  localparam int unsigned rs1_flag_bit = 7;

endpackage

// File: design/rvv_arch_pkg.sv
/*
 * Vector architectural configuration
 * Types for vl, vstart, the vtype fields and the fixed-point rounding mode,
 * plus the configuration state after reset
 */
package rvv_arch_pkg;

  // Vector length and first active element
  typedef logic [31:0] vl_t;
  typedef logic [6:0]  vstart_t;

  // Element width, vtype.vsew encoding
  typedef enum logic [2:0] {
    sew8  = 3'b000,
    sew16 = 3'b001,
    sew32 = 3'b010
  } rvv_sew_e;

  // Register grouping, vtype.vlmul encoding
  // Code 3'b100 is reserved by the spec
  typedef enum logic [2:0] {
    lmul1    = 3'b000,
    lmul2    = 3'b001,
    lmul4    = 3'b010,
    lmul8    = 3'b011,
    lmul_1_8 = 3'b101,
    lmul_1_4 = 3'b110,
    lmul_1_2 = 3'b111
  } rvv_lmul_e;

  // Fixed-point rounding, vxrm CSR
  typedef enum logic [1:0] {
    xrm_rnu = 2'b00,
    xrm_rne = 2'b01,
    xrm_rdn = 2'b10,
    xrm_rod = 2'b11
  } rvv_xrm_e;

  // Configuration in force for one instruction
  typedef struct packed {
    vl_t       vl;
    vstart_t   vstart;
    rvv_xrm_e  xrm;
    rvv_sew_e  sew;
    rvv_lmul_e lmul;
    logic      ta;
    logic      ma;
  } rvv_config_t;

  // State after reset: 16 bytes of sew8 in a single register
  localparam rvv_config_t config_reset = '{
    vl:     vl_t'(16),
    vstart: '0,
    xrm:    xrm_rnu,
    sew:    sew8,
    lmul:   lmul1,
    ta:     1'b0,
    ma:     1'b0
  };

endpackage
